//--- src/core_macros.svh
`ifndef CORE_MACROS_SVH
`define CORE_MACROS_SVH

// Datapath and storage sizes.
`define CORE_DATA_W      16
`define CORE_NUM_REGS    8
`define CORE_MEM_DEPTH   32

// Stages an accepted instruction occupies before its result is in the register file.
`define CORE_PIPE_DEPTH  3

// Opcode encodings in instruction bits 15:12.
// Codes 8 to 15 are no-ops.
`define CORE_OP_ADD      4'd0
`define CORE_OP_SUB      4'd1
`define CORE_OP_AND      4'd2
`define CORE_OP_OR       4'd3
`define CORE_OP_XOR      4'd4
`define CORE_OP_ADDI     4'd5
`define CORE_OP_LD       4'd6
`define CORE_OP_ST       4'd7

`endif

//--- src/isa_pkg.sv
`include "core_macros.svh"

package isa_pkg;

    // One fetched instruction word.
    typedef logic [`CORE_DATA_W-1:0] instr_t;

    // Opcode field, bits 15:12.
    typedef logic [3:0] opcode_t;

    // Register number, used for rd (10:8), rs1 (7:5) and rs2 (4:2).
    typedef logic [$clog2(`CORE_NUM_REGS)-1:0] reg_idx_t;

    // Immediate field, bits 4:0, zero-extended when used.
    typedef logic [4:0] imm_t;

endpackage

//--- src/pipe_pkg.sv
`include "core_macros.svh"

package pipe_pkg;

    // Data word carried between stages and held in registers and memory.
    typedef logic [`CORE_DATA_W-1:0] word_t;

    // Data memory word address.
    typedef logic [$clog2(`CORE_MEM_DEPTH)-1:0] mem_addr_t;

endpackage

//--- src/register_file.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module register_file
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    output word_t    rs1_data,
    output word_t    rs2_data,
    input  logic     wr_en,
    input  reg_idx_t wr_idx,
    input  word_t    wr_data
);
    word_t regs [`CORE_NUM_REGS];

    // Reads see the stored value only; issue holds readers until the write edge has passed.
    assign rs1_data = regs[rs1_idx];
    assign rs2_data = regs[rs2_idx];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

endmodule

//--- src/issue_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module issue_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     instr_valid,
    input  instr_t   instr,
    output logic     instr_ready,
    output reg_idx_t rs1_idx,
    output reg_idx_t rs2_idx,
    input  word_t    rs1_data,
    input  word_t    rs2_data,
    output logic     iss_valid,
    output opcode_t  iss_op,
    output reg_idx_t iss_rd,
    output word_t    iss_a,
    output word_t    iss_b,
    output imm_t     iss_imm
);
    opcode_t  dec_op;
    reg_idx_t dec_rd;
    imm_t     dec_imm;
    logic     dec_writes;
    logic     dec_store;
    logic     src1_used;
    logic     src2_used;
    logic     hazard;
    logic     accept;
    logic     run;

    // Destinations of the instructions in issue, execute and memory, youngest first.
    reg_idx_t pend_rd [`CORE_PIPE_DEPTH];
    logic     pend_we [`CORE_PIPE_DEPTH];

    assign dec_op  = instr[15:12];
    assign dec_rd  = instr[10:8];
    assign dec_imm = instr[4:0];

    assign dec_writes = dec_op inside {`CORE_OP_ADD, `CORE_OP_SUB, `CORE_OP_AND,
                                       `CORE_OP_OR, `CORE_OP_XOR, `CORE_OP_ADDI,
                                       `CORE_OP_LD};
    assign dec_store  = (dec_op == `CORE_OP_ST);

    // A store reads its data from rd through the second read port.
    assign rs1_idx   = instr[7:5];
    assign rs2_idx   = dec_store ? dec_rd : instr[4:2];
    assign src1_used = dec_writes || dec_store;
    assign src2_used = dec_store || (dec_op inside {`CORE_OP_ADD, `CORE_OP_SUB,
                                                    `CORE_OP_AND, `CORE_OP_OR,
                                                    `CORE_OP_XOR});

    always_comb begin
        hazard = 1'b0;
        for (int i = 0; i < `CORE_PIPE_DEPTH; i++) begin
            if (pend_we[i] && ((src1_used && pend_rd[i] == rs1_idx) ||
                               (src2_used && pend_rd[i] == rs2_idx))) begin
                hazard = 1'b1;
            end
        end
    end

    assign instr_ready = run && !hazard;
    assign accept      = instr_valid && instr_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            run       <= 1'b0;
            iss_valid <= 1'b0;
            for (int i = 0; i < `CORE_PIPE_DEPTH; i++) begin
                pend_we[i] <= 1'b0;
            end
        end else begin
            run        <= 1'b1;
            iss_valid  <= accept;
            pend_we[0] <= accept && dec_writes;
            for (int i = 1; i < `CORE_PIPE_DEPTH; i++) begin
                pend_we[i] <= pend_we[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        pend_rd[0] <= dec_rd;
        for (int i = 1; i < `CORE_PIPE_DEPTH; i++) begin
            pend_rd[i] <= pend_rd[i-1];
        end
        if (accept) begin
            iss_op  <= dec_op;
            iss_rd  <= dec_rd;
            iss_a   <= rs1_data;
            iss_b   <= rs2_data;
            iss_imm <= dec_imm;
        end
    end

    // No instruction may be taken in the cycle that follows a reset edge.
    a_no_ready_in_reset: assert property (@(posedge clk) reset |=> !instr_ready);

endmodule

//--- src/execute_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module execute_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     iss_valid,
    input  opcode_t  iss_op,
    input  reg_idx_t iss_rd,
    input  word_t    iss_a,
    input  word_t    iss_b,
    input  imm_t     iss_imm,
    output logic     ex_valid,
    output opcode_t  ex_op,
    output reg_idx_t ex_rd,
    output word_t    ex_result,
    output word_t    ex_store_data
);
    word_t imm_ext;
    word_t alu_out;

    assign imm_ext = {{(`CORE_DATA_W - $bits(imm_t)){1'b0}}, iss_imm};

    always_comb begin
        case (iss_op)
            `CORE_OP_ADD: alu_out = iss_a + iss_b;
            `CORE_OP_SUB: alu_out = iss_a - iss_b;
            `CORE_OP_AND: alu_out = iss_a & iss_b;
            `CORE_OP_OR:  alu_out = iss_a | iss_b;
            `CORE_OP_XOR: alu_out = iss_a ^ iss_b;
            // Immediate add and the load/store address share one adder.
            `CORE_OP_ADDI, `CORE_OP_LD, `CORE_OP_ST: alu_out = iss_a + imm_ext;
            default: alu_out = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
        end else begin
            ex_valid <= iss_valid;
        end
    end

    always_ff @(posedge clk) begin
        ex_op         <= iss_op;
        ex_rd         <= iss_rd;
        ex_result     <= alu_out;
        ex_store_data <= iss_b;
    end

    a_ex_follows_iss: assert property (@(posedge clk) disable iff (reset)
        ex_valid == $past(iss_valid));

endmodule

//--- src/memory_stage.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module memory_stage
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     ex_valid,
    input  opcode_t  ex_op,
    input  reg_idx_t ex_rd,
    input  word_t    ex_result,
    input  word_t    ex_store_data,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);
    word_t     mem [`CORE_MEM_DEPTH];
    mem_addr_t addr;
    logic      ex_writes;
    logic      do_store;

    // Address wraps to the low bits of the computed sum.
    assign addr = ex_result[$bits(mem_addr_t)-1:0];

    assign ex_writes = ex_op inside {`CORE_OP_ADD, `CORE_OP_SUB, `CORE_OP_AND,
                                     `CORE_OP_OR, `CORE_OP_XOR, `CORE_OP_ADDI,
                                     `CORE_OP_LD};
    assign do_store  = ex_valid && (ex_op == `CORE_OP_ST);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CORE_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (do_store) begin
            mem[addr] <= ex_store_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wb_valid <= 1'b0;
        end else begin
            wb_valid <= ex_valid && ex_writes;
        end
    end

    // Only one instruction sits here at a time, so a load never meets a store on the same edge.
    always_ff @(posedge clk) begin
        wb_rd <= ex_rd;
        if (ex_op == `CORE_OP_LD) begin
            wb_data <= mem[addr];
        end else begin
            wb_data <= ex_result;
        end
    end

    // The store code and every code above it leave the register file alone.
    a_no_wb_for_store_or_nop: assert property (@(posedge clk) disable iff (reset)
        (ex_valid && ex_op >= `CORE_OP_ST) |=> !wb_valid);

endmodule

//--- src/cpu_backend.sv
`timescale 1ns/1ps

module cpu_backend
    import isa_pkg::*;
    import pipe_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     instr_valid,
    input  instr_t   instr,
    output logic     instr_ready,
    output logic     wb_valid,
    output reg_idx_t wb_rd,
    output word_t    wb_data
);
    reg_idx_t rs1_idx;
    reg_idx_t rs2_idx;
    word_t    rs1_data;
    word_t    rs2_data;

    logic     iss_valid;
    opcode_t  iss_op;
    reg_idx_t iss_rd;
    word_t    iss_a;
    word_t    iss_b;
    imm_t     iss_imm;

    logic     ex_valid;
    opcode_t  ex_op;
    reg_idx_t ex_rd;
    word_t    ex_result;
    word_t    ex_store_data;

    issue_stage issue_stage_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .rs1_idx     (rs1_idx),
        .rs2_idx     (rs2_idx),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .iss_valid   (iss_valid),
        .iss_op      (iss_op),
        .iss_rd      (iss_rd),
        .iss_a       (iss_a),
        .iss_b       (iss_b),
        .iss_imm     (iss_imm)
    );

    // Write port is fed straight from the writeback register.
    register_file register_file_i (
        .clk      (clk),
        .reset    (reset),
        .rs1_idx  (rs1_idx),
        .rs2_idx  (rs2_idx),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wr_en    (wb_valid),
        .wr_idx   (wb_rd),
        .wr_data  (wb_data)
    );

    execute_stage execute_stage_i (
        .clk           (clk),
        .reset         (reset),
        .iss_valid     (iss_valid),
        .iss_op        (iss_op),
        .iss_rd        (iss_rd),
        .iss_a         (iss_a),
        .iss_b         (iss_b),
        .iss_imm       (iss_imm),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data)
    );

    memory_stage memory_stage_i (
        .clk           (clk),
        .reset         (reset),
        .ex_valid      (ex_valid),
        .ex_op         (ex_op),
        .ex_rd         (ex_rd),
        .ex_result     (ex_result),
        .ex_store_data (ex_store_data),
        .wb_valid      (wb_valid),
        .wb_rd         (wb_rd),
        .wb_data       (wb_data)
    );

endmodule

//--- verif/backend_ref_model.svh
`ifndef BACKEND_REF_MODEL_SVH
`define BACKEND_REF_MODEL_SVH

// Architectural state, updated in acceptance order.
word_t model_regs [`CORE_NUM_REGS];
word_t model_mem  [`CORE_MEM_DEPTH];

// Writebacks still to come, oldest first.
reg_idx_t exp_rd_q    [$];
word_t    exp_data_q  [$];
int       exp_cycle_q [$];
string    exp_name_q  [$];

string op_names [8] = '{"add", "sub", "and", "or", "xor", "addi", "ld", "st"};

task automatic model_reset();
    for (int i = 0; i < `CORE_NUM_REGS; i++) begin
        model_regs[i] = '0;
    end
    for (int i = 0; i < `CORE_MEM_DEPTH; i++) begin
        model_mem[i] = '0;
    end
endtask

task automatic pop_expected();
    void'(exp_rd_q.pop_front());
    void'(exp_data_q.pop_front());
    void'(exp_cycle_q.pop_front());
    void'(exp_name_q.pop_front());
endtask

// Due is the cycle in which the writeback has to be seen.
task automatic model_execute(input instr_t ins, input int due);
    opcode_t   op;
    reg_idx_t  rd;
    word_t     a;
    word_t     b;
    word_t     sum;
    word_t     res;
    mem_addr_t addr;
    logic      writes;
    op     = ins[15:12];
    rd     = ins[10:8];
    a      = model_regs[ins[7:5]];
    b      = model_regs[ins[4:2]];
    sum    = a + {{(`CORE_DATA_W - 5){1'b0}}, ins[4:0]};
    addr   = sum[4:0];
    res    = '0;
    writes = 1'b1;
    case (op)
        `CORE_OP_ADD:  res = a + b;
        `CORE_OP_SUB:  res = a - b;
        `CORE_OP_AND:  res = a & b;
        `CORE_OP_OR:   res = a | b;
        `CORE_OP_XOR:  res = a ^ b;
        `CORE_OP_ADDI: res = sum;
        `CORE_OP_LD:   res = model_mem[addr];
        `CORE_OP_ST: begin
            // Store data comes from the rd field.
            model_mem[addr] = model_regs[rd];
            writes = 1'b0;
        end
        default: writes = 1'b0;
    endcase
    if (writes) begin
        model_regs[rd] = res;
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(res);
        exp_cycle_q.push_back(due);
        exp_name_q.push_back(op_names[op[2:0]]);
    end
endtask

`endif

//--- verif/cpu_backend_tb.sv
`timescale 1ns/1ps
`include "core_macros.svh"

module cpu_backend_tb
    import isa_pkg::*;
    import pipe_pkg::*;
();
    localparam int NUM_RANDOM  = 400;
    localparam int READY_LIMIT = 20;
    localparam int DRAIN_LIMIT = 40;

    logic     clk = 1'b0;
    logic     reset;
    logic     instr_valid;
    instr_t   instr;
    logic     instr_ready;
    logic     wb_valid;
    reg_idx_t wb_rd;
    word_t    wb_data;

    integer seed;
    int     cycle = 0;
    logic   prev_reset = 1'b1;
    int     value_errors = 0;
    int     protocol_errors = 0;
    int     timeout_errors = 0;

    `include "backend_ref_model.svh"

    cpu_backend cpu_backend_i (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .instr_ready (instr_ready),
        .wb_valid    (wb_valid),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic finish_run();
        $display("Errors: %0d value, %0d protocol, %0d timeout",
                 value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic check_writeback();
        if (exp_rd_q.size() == 0) begin
            $display("Unexpected writeback to r%0d with data %h at cycle %0d",
                     wb_rd, wb_data, cycle);
            protocol_errors++;
        end else begin
            if (exp_cycle_q[0] != cycle) begin
                $display("error %s latency: expected cycle %0d, actual cycle %0d",
                         exp_name_q[0], exp_cycle_q[0], cycle);
                value_errors++;
            end
            if (wb_rd !== exp_rd_q[0] || wb_data !== exp_data_q[0]) begin
                $display("error %s: expected r%0d = %h, actual r%0d = %h",
                         exp_name_q[0], exp_rd_q[0], exp_data_q[0], wb_rd, wb_data);
                value_errors++;
            end
            pop_expected();
        end
    endtask

    // Falling edge sampling, half a cycle clear of the DUT's updates.
    always @(negedge clk) begin
        if (reset || prev_reset) begin
            if (instr_ready !== 1'b0 || wb_valid !== 1'b0) begin
                $display("instr_ready or wb_valid high in or right after reset at cycle %0d",
                         cycle);
                protocol_errors++;
            end
        end else begin
            if (wb_valid) begin
                check_writeback();
            end else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle) begin
                $display("No writeback from %s to r%0d by cycle %0d",
                         exp_name_q[0], exp_rd_q[0], exp_cycle_q[0]);
                protocol_errors++;
                pop_expected();
            end
            // Accepted at the next edge, so its writeback shows up three samples on
            if (instr_valid && instr_ready) begin
                model_execute(instr, cycle + `CORE_PIPE_DEPTH);
            end
        end
        prev_reset = reset;
    end

    function automatic instr_t make_instr(input opcode_t op, input reg_idx_t rd,
                                          input reg_idx_t rs1, input imm_t low);
        return {op, 1'b0, rd, rs1, low};
    endfunction

    // Loads and stores dominate, with low sources and offsets to force reuse.
    function automatic instr_t random_instr();
        logic [31:0] r;
        opcode_t     op;
        imm_t        low;
        r   = $random(seed);
        low = r[13:9];
        if (r[3:0] < 4'd4) begin
            op  = `CORE_OP_LD;
            low = {2'b00, r[9:7]};
        end else if (r[3:0] < 4'd8) begin
            op  = `CORE_OP_ST;
            low = {2'b00, r[9:7]};
        end else if (r[3:0] == 4'd15) begin
            op = {1'b1, r[6:4]};
        end else begin
            op = {1'b0, r[6:4]};
        end
        return make_instr(op, r[16:14], {1'b0, r[18:17]}, low);
    endfunction

    task automatic send_instr(input instr_t ins);
        int waited;
        instr_valid = 1'b1;
        instr       = ins;
        waited      = 0;
        @(negedge clk);
        while (!instr_ready && waited < READY_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (instr_ready) begin
            @(posedge clk);
            #1;
            instr_valid = 1'b0;
        end else begin
            $display("instr_ready stayed low for %0d cycles with instruction %h waiting",
                     READY_LIMIT, ins);
            timeout_errors++;
            finish_run();
        end
    endtask

    initial begin
        logic [31:0] r;
        int          waited;
        seed        = 32'h2706_b62a;
        reset       = 1'b1;
        instr_valid = 1'b0;
        instr       = '0;
        model_reset();
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // Fresh state reads as zero.
        send_instr(make_instr(`CORE_OP_LD, 3'd1, 3'd6, 5'd19));
        send_instr(make_instr(`CORE_OP_ADD, 3'd2, 3'd5, {3'd7, 2'b00}));

        // Dependent chain, with a store, its reload and a use of the load.
        send_instr(make_instr(`CORE_OP_ADDI, 3'd1, 3'd1, 5'd9));
        send_instr(make_instr(`CORE_OP_ADD, 3'd2, 3'd1, {3'd1, 2'b00}));
        send_instr(make_instr(`CORE_OP_SUB, 3'd3, 3'd2, {3'd1, 2'b00}));
        send_instr(make_instr(`CORE_OP_ST, 3'd3, 3'd1, 5'd2));
        send_instr(make_instr(`CORE_OP_LD, 3'd4, 3'd1, 5'd2));
        send_instr(make_instr(`CORE_OP_XOR, 3'd5, 3'd4, {3'd2, 2'b00}));
        send_instr(make_instr(`CORE_OP_OR, 3'd6, 3'd5, {3'd3, 2'b00}));
        send_instr(make_instr(`CORE_OP_AND, 3'd7, 3'd6, {3'd4, 2'b00}));

        for (int n = 0; n < NUM_RANDOM; n++) begin
            send_instr(random_instr());
            r = $random(seed);
            if (r[1:0] == 2'b00) begin
                repeat (r[3:2] + 1) @(posedge clk);
                #1;
            end
        end

        // The queues only change on falling edges, so they are read on rising ones.
        waited = 0;
        while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("%0d writebacks still outstanding after %0d cycles",
                     exp_rd_q.size(), DRAIN_LIMIT);
            timeout_errors++;
        end
        // A late stray event still lands in this window.
        repeat (2 * `CORE_PIPE_DEPTH) @(posedge clk);
        finish_run();
    end

endmodule

//--- filelist.f
+incdir+src
+incdir+verif
src/isa_pkg.sv
src/pipe_pkg.sv
src/register_file.sv
src/issue_stage.sv
src/execute_stage.sv
src/memory_stage.sv
src/cpu_backend.sv
verif/cpu_backend_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_backend_tb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal
PASS_TEXT ?= TEST RESULT: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard src/*.svh verif/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
